//--- compile.f
source/sdram_cfg_pkg.sv
source/sdram_cmd_pkg.sv
source/sdram_refresh_timer.sv
source/sdram_bank_tracker.sv
source/sdram_scheduler.sv
source/sdram_cmd_issue.sv
source/sdram_read_capture.sv
source/sdram_ctrl_top.sv
sim/sdram_model.sv
sim/tb_sdram_ctrl.sv

//--- sim/sdram_cases.txt
# op (W write, R read, I idle) addr be wdata expected_rdata, all hex
# idle lines give the cycle count in the wdata column
W 000100 f 11223344 00000000
R 000100 0 00000000 11223344
W 000100 5 aabbccdd 00000000
R 000100 0 00000000 11bb33dd
W 002104 f cafef00d 00000000
R 000100 0 00000000 11bb33dd
I 000000 0 000000fa 00000000
R 002104 0 00000000 cafef00d
W 001800 8 5a000000 00000000
I 000000 0 000000fa 00000000
R 001800 0 00000000 5a000000
R 000100 0 00000000 11bb33dd

//--- sim/tb_sdram_ctrl.sv
/*
 * Testbench for the SDRAM controller. Replays requests from the cases file
 * against the behavioral SDRAM and checks data and ack timing.
 */
`default_nettype none

module tb_sdram_ctrl;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int START_DELAY      = 200;
  localparam int REFRESH_INTERVAL = 300;
  localparam int READ_LATENCY     = 2;
  localparam int MAX_CASES        = 64;

  logic        clk_i;
  logic        rst_i;
  logic [3:0]  req_wr_i;
  logic        req_rd_i;
  logic [23:0] req_addr_i;
  logic [31:0] req_wdata_i;
  wire         req_accept_o;
  wire         ack_o;
  wire  [31:0] rdata_o;
  wire         cke;
  wire         cs;
  wire         ras;
  wire         cas;
  wire         we;
  wire         dq_oe;
  wire  [1:0]  ba;
  wire  [12:0] addr;
  wire  [3:0]  dqm;
  wire  [31:0] dq_to_mem;
  wire  [31:0] dq_from_mem;
  wire         model_init_done;
  wire         model_error;

  // Case table
  logic [7:0]  op_q    [MAX_CASES];
  logic [23:0] addr_q  [MAX_CASES];
  logic [3:0]  be_q    [MAX_CASES];
  logic [31:0] wdata_q [MAX_CASES];
  logic [31:0] exp_q   [MAX_CASES];
  int          num_cases;
  logic        cases_loaded;

  // Outstanding acks with due cycle and expected data
  int          ack_cycle_q [$];
  logic        ack_rd_q    [$];
  logic [31:0] ack_data_q  [$];
  int          cycle;
  logic [31:0] cur_exp;

  sdram_ctrl_top #(
    .START_DELAY      (START_DELAY),
    .REFRESH_INTERVAL (REFRESH_INTERVAL),
    .READ_LATENCY     (READ_LATENCY)
  ) u_sdram_ctrl_top (
    .clk_i (clk_i), .rst_i (rst_i),
    .req_wr_i (req_wr_i), .req_rd_i (req_rd_i),
    .req_addr_i (req_addr_i), .req_wdata_i (req_wdata_i),
    .req_accept_o (req_accept_o), .ack_o (ack_o), .rdata_o (rdata_o),
    .sdram_cke_o (cke), .sdram_cs_o (cs), .sdram_ras_o (ras),
    .sdram_cas_o (cas), .sdram_we_o (we), .sdram_ba_o (ba),
    .sdram_addr_o (addr), .sdram_dqm_o (dqm), .sdram_dq_o (dq_to_mem),
    .sdram_dq_oe_o (dq_oe), .sdram_dq_i (dq_from_mem)
  );

  sdram_model #(
    .MAX_REFRESH_GAP (REFRESH_INTERVAL + 50)
  ) u_model (
    .clk_i (clk_i), .cke_i (cke), .cs_i (cs), .ras_i (ras), .cas_i (cas),
    .we_i (we), .ba_i (ba), .addr_i (addr), .dqm_i (dqm), .dq_i (dq_to_mem),
    .dq_oe_i (dq_oe), .dq_o (dq_from_mem),
    .init_done_o (model_init_done), .error_o (model_error)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic check_equal(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "run stopped");
  endtask

  task automatic load_cases();
    int          fd;
    int          n;
    string       rest;
    logic [63:0] tok;
    num_cases = 0;
    fd = $fopen("sim/sdram_cases.txt", "r");
    if (fd == 0) stop_on_failure("Cannot open sim/sdram_cases.txt");
    while (!$feof(fd) && num_cases < MAX_CASES) begin
      tok = '0;
      n = $fscanf(fd, "%s", tok);
      if (n == 1) begin
        // Comment lines start with a hash
        if (tok[7:0] == "#") begin
          n = $fgets(rest, fd);
        end else begin
          op_q[num_cases] = tok[7:0];
          n = $fscanf(fd, "%h %h %h %h", addr_q[num_cases], be_q[num_cases],
                      wdata_q[num_cases], exp_q[num_cases]);
          num_cases++;
        end
      end
    end
    $fclose(fd);
  endtask

  // Present one request and hold it until the accept edge
  task automatic send_request(input int idx);
    req_addr_i  = addr_q[idx];
    req_wdata_i = wdata_q[idx];
    req_rd_i    = (op_q[idx] == "R");
    req_wr_i    = (op_q[idx] == "W") ? be_q[idx] : 4'h0;
    cur_exp     = exp_q[idx];
    do @(posedge clk_i); while (!req_accept_o);
    #2;
    req_rd_i = 1'b0;
    req_wr_i = 4'h0;
  endtask

  // Accept and ack bookkeeping at each rising edge
  always @(posedge clk_i) begin
    cycle = cycle + 1;
    if (!rst_i && req_accept_o) begin
      if (!model_init_done) stop_on_failure("Request accepted before LOAD MODE");
      ack_cycle_q.push_back(cycle + (req_rd_i ? READ_LATENCY + 3 : 1));
      ack_rd_q.push_back(req_rd_i);
      ack_data_q.push_back(cur_exp);
    end
    if (!rst_i && ack_o) begin
      if (ack_cycle_q.size() == 0) stop_on_failure("Ack without an accepted request");
      check_equal("ack cycle", 32'(cycle), 32'(ack_cycle_q.pop_front()));
      if (ack_rd_q.pop_front()) begin
        check_equal("read data", rdata_o, ack_data_q.pop_front());
      end else begin
        void'(ack_data_q.pop_front());
      end
    end
  end

  initial begin
    wait (model_error === 1'b1);
    stop_on_failure("SDRAM model saw an illegal command sequence");
  end

  // Watchdog sized from the case count
  initial begin
    wait (cases_loaded === 1'b1);
    repeat (num_cases * 40 + START_DELAY + 500) @(posedge clk_i);
    stop_on_failure("Timeout, the run did not finish in time");
  end

  initial begin
    rst_i        = 1'b1;
    req_wr_i     = 4'h0;
    req_rd_i     = 1'b0;
    req_addr_i   = '0;
    req_wdata_i  = '0;
    cur_exp      = '0;
    cycle        = 0;
    cases_loaded = 1'b0;
    load_cases();
    cases_loaded = 1'b1;
    repeat (3) @(posedge clk_i);
    #2 rst_i = 1'b0;
    for (int i = 0; i < num_cases; i++) begin
      if (op_q[i] == "I") begin
        // Idle gap with its cycle count in the data column
        repeat (wdata_q[i]) @(posedge clk_i);
        #2;
      end else begin
        send_request(i);
      end
    end
    // Last read ack is due READ_LATENCY+3 cycles after the last accept
    repeat (READ_LATENCY + 4) @(posedge clk_i);
    #2;
    if (ack_cycle_q.size() != 0) begin
      stop_on_failure("Acks still outstanding at the end");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- sim/sdram_model.sv
/*
 * Behavioral SDR SDRAM for simulation. Checks power-up order, bank state and
 * refresh spacing, stores masked writes and returns reads at CAS latency 2.
 */
`default_nettype none

module sdram_model #(
  parameter int MAX_REFRESH_GAP = 350
) (
  input  wire        clk_i,
  input  wire        cke_i,
  input  wire        cs_i,
  input  wire        ras_i,
  input  wire        cas_i,
  input  wire        we_i,
  input  wire [1:0]  ba_i,
  input  wire [12:0] addr_i,
  input  wire [3:0]  dqm_i,
  input  wire [31:0] dq_i,
  input  wire        dq_oe_i,
  output logic [31:0] dq_o,
  output logic       init_done_o,
  output logic       error_o
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] mem [int];
  logic [3:0]  open_q;
  logic [12:0] row_q [4];
  logic [31:0] pipe_q;
  logic [3:0]  cmd;
  int          init_stage;
  int          refresh_gap;

  assign cmd = {cs_i, ras_i, cas_i, we_i};

  initial begin
    dq_o        = '0;
    pipe_q      = '0;
    open_q      = '0;
    init_stage  = 0;
    refresh_gap = 0;
    init_done_o = 1'b0;
    error_o     = 1'b0;
  end

  task automatic flag(input string msg);
    $display("SDRAM model at %0t: %s", $time, msg);
    error_o = 1'b1;
  endtask

  function automatic int mem_key(input logic [1:0] ba, input logic [12:0] row,
                                 input logic [8:0] col);
    return int'({ba, row, col});
  endfunction

  always @(posedge clk_i) begin
    logic [31:0] word;
    int          key;
    // Read data appears two edges after the READ edge
    dq_o   <= pipe_q;
    pipe_q <= '0;
    if (init_done_o) begin
      refresh_gap = refresh_gap + 1;
      if (refresh_gap > MAX_REFRESH_GAP) flag("refresh interval exceeded");
    end
    if (!cke_i) begin
      if (cmd != 4'b0111) flag("command issued while CKE is low");
    end else if (!init_done_o && cmd != 4'b0111) begin
      // Power-up order is PRECHARGE all, REFRESH, REFRESH, LOAD MODE
      case (init_stage)
        0: if (cmd != 4'b0010 || !addr_i[10]) flag("power-up needs PRECHARGE all first");
        1, 2: if (cmd != 4'b0001) flag("power-up needs two REFRESH commands");
        default: begin
          if (cmd != 4'b0000) flag("power-up needs LOAD MODE last");
          else if (addr_i != 13'h020) flag("wrong mode register word");
          init_done_o = 1'b1;
        end
      endcase
      init_stage = init_stage + 1;
      if (cmd == 4'b0001) refresh_gap = 0;
    end else begin
      key = mem_key(ba_i, row_q[ba_i], addr_i[8:0]);
      case (cmd)
        4'b0111: ;
        4'b0011: begin
          if (open_q[ba_i]) flag("ACTIVATE on a bank that is already open");
          open_q[ba_i] = 1'b1;
          row_q[ba_i]  = addr_i;
        end
        4'b0010: begin
          if (addr_i[10]) open_q = '0;
          else open_q[ba_i] = 1'b0;
        end
        4'b0001: begin
          if (open_q != '0) flag("REFRESH while a bank is open");
          refresh_gap = 0;
        end
        4'b0101: begin
          if (!open_q[ba_i]) flag("READ on a closed bank");
          pipe_q <= mem.exists(key) ? mem[key] : 32'h0;
        end
        4'b0100: begin
          if (!open_q[ba_i]) flag("WRITE on a closed bank");
          if (!dq_oe_i) flag("WRITE without data output enable");
          word = mem.exists(key) ? mem[key] : 32'h0;
          for (int b = 0; b < 4; b++) begin
            if (!dqm_i[b]) word[8*b +: 8] = dq_i[8*b +: 8];
          end
          mem[key] = word;
        end
        default: flag("LOAD MODE after power-up or unknown command");
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/sdram_ctrl_top.sv
/*
 * Single-word SDRAM controller top. Host request/accept/ack port on one side,
 * SDR SDRAM pins on the other. Timing parameters are set here and passed down.
 */
`default_nettype none

module sdram_ctrl_top #(
  parameter int          CLK_MHZ          = 50,
  // 100 us power-up wait, 8192 refreshes per 64 ms
  parameter int unsigned START_DELAY      = 100 * CLK_MHZ,
  parameter int unsigned REFRESH_INTERVAL = (64000 * CLK_MHZ) / (2 ** sdram_cfg_pkg::ROW_W) - 1,
  parameter int          READ_LATENCY     = 2
) (
  input  wire                              clk_i,
  input  wire                              rst_i,
  // Host side
  input  wire  [sdram_cfg_pkg::DQM_W-1:0]  req_wr_i,
  input  wire                              req_rd_i,
  input  wire  [sdram_cfg_pkg::ADDR_W-1:0] req_addr_i,
  input  wire  [sdram_cfg_pkg::DATA_W-1:0] req_wdata_i,
  output logic                             req_accept_o,
  output logic                             ack_o,
  output logic [sdram_cfg_pkg::DATA_W-1:0] rdata_o,
  // SDRAM side
  output logic                             sdram_cke_o,
  output logic                             sdram_cs_o,
  output logic                             sdram_ras_o,
  output logic                             sdram_cas_o,
  output logic                             sdram_we_o,
  output sdram_cfg_pkg::bank_t             sdram_ba_o,
  output sdram_cfg_pkg::row_t              sdram_addr_o,
  output logic [sdram_cfg_pkg::DQM_W-1:0]  sdram_dqm_o,
  output logic [sdram_cfg_pkg::DATA_W-1:0] sdram_dq_o,
  output logic                             sdram_dq_oe_o,
  input  wire  [sdram_cfg_pkg::DATA_W-1:0] sdram_dq_i
);

  import sdram_cmd_pkg::*;

  sched_state_e sched_state;
  int unsigned  timer_step;
  logic         refresh_pend;
  logic         refresh_done;
  logic         row_hit;
  logic         bank_open;
  logic         any_open;
  logic         open_row;
  logic         close_bank;
  logic         close_all;
  logic         rd_issue;

  sdram_refresh_timer #(
    .START_DELAY      (START_DELAY),
    .REFRESH_INTERVAL (REFRESH_INTERVAL)
  ) u_refresh (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .refresh_done_i (refresh_done),
    .refresh_pend_o (refresh_pend),
    .init_step_o    (timer_step)
  );

  sdram_bank_tracker u_banks (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_addr_i   (req_addr_i),
    .open_i       (open_row),
    .close_bank_i (close_bank),
    .close_all_i  (close_all),
    .row_hit_o    (row_hit),
    .bank_open_o  (bank_open),
    .any_open_o   (any_open)
  );

  sdram_scheduler #(
    .READ_LATENCY (READ_LATENCY)
  ) u_sched (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_wr_i       (req_wr_i),
    .req_rd_i       (req_rd_i),
    .refresh_pend_i (refresh_pend),
    .row_hit_i      (row_hit),
    .bank_open_i    (bank_open),
    .any_open_i     (any_open),
    .state_o        (sched_state),
    .accept_o       (req_accept_o),
    .open_o         (open_row),
    .close_bank_o   (close_bank),
    .close_all_o    (close_all),
    .rd_issue_o     (rd_issue),
    .refresh_done_o (refresh_done)
  );

  sdram_cmd_issue u_issue (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .state_i       (sched_state),
    .init_step_i   (timer_step),
    .req_addr_i    (req_addr_i),
    .req_wr_i      (req_wr_i),
    .req_wdata_i   (req_wdata_i),
    .close_all_i   (close_all),
    .sdram_cke_o   (sdram_cke_o),
    .sdram_cs_o    (sdram_cs_o),
    .sdram_ras_o   (sdram_ras_o),
    .sdram_cas_o   (sdram_cas_o),
    .sdram_we_o    (sdram_we_o),
    .sdram_ba_o    (sdram_ba_o),
    .sdram_addr_o  (sdram_addr_o),
    .sdram_dqm_o   (sdram_dqm_o),
    .sdram_dq_o    (sdram_dq_o),
    .sdram_dq_oe_o (sdram_dq_oe_o)
  );

  // Accepted request that is not a read is a write
  sdram_read_capture #(
    .READ_LATENCY (READ_LATENCY)
  ) u_capture (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .rd_issue_i   (rd_issue),
    .write_done_i (req_accept_o && !rd_issue),
    .sdram_dq_i   (sdram_dq_i),
    .rdata_o      (rdata_o),
    .ack_o        (ack_o)
  );

endmodule

`default_nettype wire

//--- source/sdram_read_capture.sv
/*
 * Read return path. Two-stage capture of the data pins, a delay line for
 * read events and the host ack for reads and writes.
 */
`default_nettype none

module sdram_read_capture #(
  parameter int READ_LATENCY = 2
) (
  input  wire                              clk_i,
  input  wire                              rst_i,
  input  wire                              rd_issue_i,
  input  wire                              write_done_i,
  input  wire  [sdram_cfg_pkg::DATA_W-1:0] sdram_dq_i,
  output logic [sdram_cfg_pkg::DATA_W-1:0] rdata_o,
  output logic                             ack_o
);

  import sdram_cfg_pkg::*;

  logic [DATA_W-1:0]       sample0_q;
  logic [DATA_W-1:0]       sample1_q;
  logic [READ_LATENCY+1:0] rd_q;
  logic                    ack_q;

  // Pad register, then a second stage for the host side
  always_ff @(posedge clk_i) begin
    sample0_q <= sdram_dq_i;
    sample1_q <= sample0_q;
  end

  // One bit per read in flight, oldest at the top
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rd_q  <= '0;
      ack_q <= 1'b0;
    end else begin
      rd_q  <= {rd_q[READ_LATENCY:0], rd_issue_i};
      ack_q <= write_done_i || rd_q[READ_LATENCY+1];
    end
  end

  assign rdata_o = sample1_q;
  assign ack_o   = ack_q;

endmodule

`default_nettype wire

//--- source/sdram_cmd_issue.sv
/*
 * Output register stage. Turns the scheduler state and the power-up steps
 * into SDRAM pin values one cycle later.
 */
`default_nettype none

module sdram_cmd_issue (
  input  wire                             clk_i,
  input  wire                             rst_i,
  input  sdram_cmd_pkg::sched_state_e     state_i,
  input  int unsigned                     init_step_i,
  input  wire [sdram_cfg_pkg::ADDR_W-1:0] req_addr_i,
  input  wire [sdram_cfg_pkg::DQM_W-1:0]  req_wr_i,
  input  wire [sdram_cfg_pkg::DATA_W-1:0] req_wdata_i,
  input  wire                             close_all_i,
  output logic                            sdram_cke_o,
  output logic                            sdram_cs_o,
  output logic                            sdram_ras_o,
  output logic                            sdram_cas_o,
  output logic                            sdram_we_o,
  output sdram_cfg_pkg::bank_t            sdram_ba_o,
  output sdram_cfg_pkg::row_t             sdram_addr_o,
  output logic [sdram_cfg_pkg::DQM_W-1:0] sdram_dqm_o,
  output logic [sdram_cfg_pkg::DATA_W-1:0] sdram_dq_o,
  output logic                            sdram_dq_oe_o
);

  import sdram_cfg_pkg::*;
  import sdram_cmd_pkg::*;

  sdram_cmd_u        cmd_q;
  row_t              addr_q;
  bank_t             ba_q;
  logic [DQM_W-1:0]  dqm_q;
  logic [DATA_W-1:0] data_q;
  logic              cke_q;
  logic              oe_q;
  row_t              col_addr;

  // Column on the low address pins with A10 low for no auto precharge
  always_comb begin
    col_addr = row_t'(addr_col(req_addr_i));
    col_addr[AUTO_PRE_BIT] = 1'b0;
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cmd_q.code <= CMD_NOP;
      addr_q     <= '0;
      ba_q       <= '0;
      dqm_q      <= '0;
      cke_q      <= 1'b0;
      oe_q       <= 1'b0;
    end else begin
      // Idle pins unless a state below says otherwise
      cmd_q.code <= CMD_NOP;
      addr_q     <= '0;
      ba_q       <= '0;
      oe_q       <= 1'b0;
      case (state_i)
        INIT: begin
          // Power-up steps keyed on the timer count
          case (init_step_i)
            50: cke_q <= 1'b1;
            40: begin
              cmd_q.code            <= CMD_PRECHARGE;
              addr_q[ALL_BANKS_BIT] <= 1'b1;
            end
            30, 20: cmd_q.code <= CMD_REFRESH;
            10: begin
              cmd_q.code <= CMD_LOAD_MODE;
              addr_q     <= MODE_WORD;
            end
            default: ;
          endcase
        end
        ACTIVATE: begin
          cmd_q.code <= CMD_ACTIVE;
          addr_q     <= addr_row(req_addr_i);
          ba_q       <= addr_bank(req_addr_i);
        end
        PRECHARGE: begin
          // All banks ahead of refresh or only the missed bank
          cmd_q.code            <= CMD_PRECHARGE;
          addr_q[ALL_BANKS_BIT] <= close_all_i;
          ba_q                  <= close_all_i ? bank_t'(0) : addr_bank(req_addr_i);
        end
        REFRESH: cmd_q.code <= CMD_REFRESH;
        READ: begin
          cmd_q.code <= CMD_READ;
          addr_q     <= col_addr;
          ba_q       <= addr_bank(req_addr_i);
          dqm_q      <= '0;
        end
        WRITE: begin
          cmd_q.code <= CMD_WRITE;
          addr_q     <= col_addr;
          ba_q       <= addr_bank(req_addr_i);
          // Mask is high for bytes the host leaves alone
          dqm_q      <= ~req_wr_i;
          oe_q       <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  // Write data rides with the WRITE command
  always_ff @(posedge clk_i) begin
    if (state_i == WRITE) begin
      data_q <= req_wdata_i;
    end
  end

  assign sdram_cke_o   = cke_q;
  assign sdram_cs_o    = cmd_q.pins.cs;
  assign sdram_ras_o   = cmd_q.pins.ras;
  assign sdram_cas_o   = cmd_q.pins.cas;
  assign sdram_we_o    = cmd_q.pins.we;
  assign sdram_ba_o    = ba_q;
  assign sdram_addr_o  = addr_q;
  assign sdram_dqm_o   = dqm_q;
  assign sdram_dq_o    = data_q;
  assign sdram_dq_oe_o = oe_q;

  // Only NOP goes out until power-up has raised the clock enable
  a_nop_until_cke: assert property (@(posedge clk_i) disable iff (rst_i)
    !sdram_cke_o |-> (cmd_q.code == CMD_NOP));

endmodule

`default_nettype wire

//--- source/sdram_scheduler.sv
/*
 * Main controller FSM. Picks the next SDRAM operation from refresh requests,
 * the open-row table and the host strobes, and times the gaps between them.
 */
`default_nettype none

module sdram_scheduler #(
  parameter int READ_LATENCY = 2
) (
  input  wire                            clk_i,
  input  wire                            rst_i,
  input  wire [sdram_cfg_pkg::DQM_W-1:0] req_wr_i,
  input  wire                            req_rd_i,
  input  wire                            refresh_pend_i,
  input  wire                            row_hit_i,
  input  wire                            bank_open_i,
  input  wire                            any_open_i,
  output sdram_cmd_pkg::sched_state_e    state_o,
  output logic                           accept_o,
  output logic                           open_o,
  output logic                           close_bank_o,
  output logic                           close_all_o,
  output logic                           rd_issue_o,
  output logic                           refresh_done_o
);

  import sdram_cfg_pkg::*;
  import sdram_cmd_pkg::*;

  sched_state_e       state_q;
  sched_state_e       next_state;
  sched_state_e       target_q;
  sched_state_e       target_d;
  sched_state_e       delay_state_q;
  logic [DELAY_W-1:0] delay_q;
  logic [DELAY_W-1:0] delay_d;
  logic               req_pend;
  logic               read_chain;

  assign req_pend   = req_rd_i || (req_wr_i != '0);
  // Next read to the same open row follows without the CAS wait
  assign read_chain = !refresh_pend_i && req_rd_i && row_hit_i;

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    next_state = state_q;
    target_d   = target_q;
    case (state_q)
      INIT: begin
        // First timer expiry marks the end of power-up
        if (refresh_pend_i) next_state = IDLE;
      end
      IDLE: begin
        if (refresh_pend_i) begin
          // Close all rows before refresh
          next_state = any_open_i ? PRECHARGE : REFRESH;
          target_d   = REFRESH;
        end else if (req_pend) begin
          if (row_hit_i) begin
            next_state = req_rd_i ? READ : WRITE;
          end else begin
            // Miss in an open bank costs a precharge first
            next_state = bank_open_i ? PRECHARGE : ACTIVATE;
            target_d   = req_rd_i ? READ : WRITE;
          end
        end
      end
      ACTIVATE:  next_state = target_q;
      READ:      next_state = READ_WAIT;
      READ_WAIT: next_state = read_chain ? READ : IDLE;
      WRITE:     next_state = IDLE;
      PRECHARGE: next_state = (target_q == REFRESH) ? REFRESH : ACTIVATE;
      REFRESH:   next_state = IDLE;
      DELAY:     next_state = delay_state_q;
      default:   next_state = IDLE;
    endcase
  end

  // ----------------------------------------
  // Wait cycles after each command
  // ----------------------------------------
  always_comb begin
    case (state_q)
      ACTIVATE:  delay_d = DELAY_W'(TRCD_CYCLES);
      READ_WAIT: delay_d = read_chain ? '0 : DELAY_W'(READ_LATENCY);
      PRECHARGE: delay_d = DELAY_W'(TRP_CYCLES);
      REFRESH:   delay_d = DELAY_W'(TRFC_CYCLES);
      DELAY:     delay_d = delay_q - DELAY_W'(1);
      default:   delay_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q       <= INIT;
      target_q      <= IDLE;
      delay_state_q <= IDLE;
      delay_q       <= '0;
    end else begin
      target_q <= target_d;
      delay_q  <= delay_d;
      // Park in DELAY and remember where to go afterwards
      if (state_q != DELAY && delay_d != '0) begin
        delay_state_q <= next_state;
      end
      state_q <= (delay_d != '0) ? DELAY : next_state;
    end
  end

  assign state_o        = state_q;
  assign accept_o       = (state_q == READ) || (state_q == WRITE);
  assign open_o         = (state_q == ACTIVATE);
  assign close_all_o    = (state_q == PRECHARGE) && (target_q == REFRESH);
  assign close_bank_o   = (state_q == PRECHARGE) && (target_q != REFRESH);
  assign rd_issue_o     = (state_q == READ);
  assign refresh_done_o = (state_q == REFRESH);

  // Accept completes a request the host is still presenting
  a_accept_pending: assert property (@(posedge clk_i) disable iff (rst_i)
    accept_o |-> (state_q inside {READ, WRITE}) && req_pend);

endmodule

`default_nettype wire

//--- source/sdram_bank_tracker.sv
/*
 * Open-row table, one entry per bank. Classifies the pending host address
 * as row hit, row miss in an open bank, or closed bank.
 */
`default_nettype none

module sdram_bank_tracker (
  input  wire                             clk_i,
  input  wire                             rst_i,
  input  wire [sdram_cfg_pkg::ADDR_W-1:0] req_addr_i,
  input  wire                             open_i,
  input  wire                             close_bank_i,
  input  wire                             close_all_i,
  output logic                            row_hit_o,
  output logic                            bank_open_o,
  output logic                            any_open_o
);

  import sdram_cfg_pkg::*;

  logic [NUM_BANKS-1:0] open_q;
  row_t                 active_row_q [NUM_BANKS];
  bank_t                req_bank;
  row_t                 req_row;

  assign req_bank = addr_bank(req_addr_i);
  assign req_row  = addr_row(req_addr_i);

  // Open flags, close wins over open
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      open_q <= '0;
    end else if (close_all_i) begin
      open_q <= '0;
    end else if (close_bank_i) begin
      open_q[req_bank] <= 1'b0;
    end else if (open_i) begin
      open_q[req_bank] <= 1'b1;
    end
  end

  // Row latched on ACTIVATE
  always_ff @(posedge clk_i) begin
    if (open_i) begin
      active_row_q[req_bank] <= req_row;
    end
  end

  assign bank_open_o = open_q[req_bank];
  assign row_hit_o   = open_q[req_bank] && (active_row_q[req_bank] == req_row);
  assign any_open_o  = |open_q;

  // Scheduler must precharge a bank before it activates another row there
  a_open_closed_bank: assert property (@(posedge clk_i) disable iff (rst_i)
    open_i |-> !open_q[req_bank]);

endmodule

`default_nettype wire

//--- source/sdram_refresh_timer.sv
/*
 * Shared down-counter. Times the power-up command steps, then raises a
 * refresh request every REFRESH_INTERVAL cycles until the scheduler serves it.
 */
`default_nettype none

module sdram_refresh_timer #(
  parameter int unsigned START_DELAY      = 5000,
  parameter int unsigned REFRESH_INTERVAL = 389
) (
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire         refresh_done_i,
  output logic        refresh_pend_o,
  output int unsigned init_step_o
);

  int unsigned count_q;
  logic        pend_q;

  // First expiry ends power-up, the margin of 100 holds the init steps
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      count_q <= START_DELAY + 100;
    end else if (count_q == 0) begin
      count_q <= REFRESH_INTERVAL;
    end else begin
      count_q <= count_q - 1;
    end
  end

  // Request stays up until a REFRESH has gone out
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      pend_q <= 1'b0;
    end else if (count_q == 0) begin
      pend_q <= 1'b1;
    end else if (refresh_done_i) begin
      pend_q <= 1'b0;
    end
  end

  assign refresh_pend_o = pend_q;
  assign init_step_o    = count_q;

endmodule

`default_nettype wire

//--- source/sdram_cmd_pkg.sv
/*
 * SDRAM command encodings, the mode register word and the scheduler states.
 */
`default_nettype none

package sdram_cmd_pkg;

  // Command pins, all active low, in code bit order
  typedef struct packed {
    logic cs;
    logic ras;
    logic cas;
    logic we;
  } sdram_pins_t;

  // Same 4 bits seen as a command code or as the pin levels
  typedef union packed {
    logic [3:0]  code;
    sdram_pins_t pins;
  } sdram_cmd_u;

  localparam logic [3:0] CMD_NOP       = 4'b0111;
  localparam logic [3:0] CMD_ACTIVE    = 4'b0011;
  localparam logic [3:0] CMD_READ      = 4'b0101;
  localparam logic [3:0] CMD_WRITE     = 4'b0100;
  localparam logic [3:0] CMD_PRECHARGE = 4'b0010;
  localparam logic [3:0] CMD_REFRESH   = 4'b0001;
  localparam logic [3:0] CMD_LOAD_MODE = 4'b0000;

  // Burst write, CAS latency 2, sequential, burst length 1
  localparam sdram_cfg_pkg::row_t MODE_WORD = {3'b000, 1'b0, 2'b00, 3'b010, 1'b0, 3'b000};

  // A10 selects all banks on PRECHARGE, auto precharge on READ/WRITE
  localparam int ALL_BANKS_BIT = 10;
  localparam int AUTO_PRE_BIT  = 10;

  typedef enum logic [3:0] {
    INIT,
    IDLE,
    ACTIVATE,
    READ,
    READ_WAIT,
    WRITE,
    PRECHARGE,
    REFRESH,
    DELAY
  } sched_state_e;

endpackage

`default_nettype wire

//--- source/sdram_cfg_pkg.sv
/*
 * Geometry, data widths and timing cycle counts of the 32-bit SDR SDRAM.
 * Also holds the split of a host byte address into row, bank and column.
 */
`default_nettype none

package sdram_cfg_pkg;

  // ----------------------------------------
  // Geometry
  // ----------------------------------------
  localparam int ADDR_W    = 24;
  localparam int COL_W     = 9;
  localparam int BANK_W    = 2;
  localparam int ROW_W     = ADDR_W - COL_W - BANK_W;
  localparam int DATA_W    = 32;
  localparam int DQM_W     = 4;
  localparam int NUM_BANKS = 2 ** BANK_W;

  // Byte offset within a word, then column, bank and row
  localparam int WORD_LSB = $clog2(DQM_W);
  localparam int BANK_LSB = WORD_LSB + COL_W;
  localparam int ROW_LSB  = BANK_LSB + BANK_W;

  typedef logic [ROW_W-1:0]  row_t;
  typedef logic [COL_W-1:0]  col_t;
  typedef logic [BANK_W-1:0] bank_t;

  // ----------------------------------------
  // Timing at 50 MHz, in clock cycles
  // ----------------------------------------
  localparam int TRCD_CYCLES = 1;
  localparam int TRP_CYCLES  = 1;
  localparam int TRFC_CYCLES = 3;
  localparam int DELAY_W     = 4;

  // Row bits above the bank field, zero padded to the address bus width
  function automatic row_t addr_row(input logic [ADDR_W-1:0] addr);
    row_t row;
    row = '0;
    row[ADDR_W-ROW_LSB-1:0] = addr[ADDR_W-1:ROW_LSB];
    return row;
  endfunction

  function automatic bank_t addr_bank(input logic [ADDR_W-1:0] addr);
    return addr[ROW_LSB-1:BANK_LSB];
  endfunction

  function automatic col_t addr_col(input logic [ADDR_W-1:0] addr);
    return addr[BANK_LSB-1:WORD_LSB];
  endfunction

endpackage

`default_nettype wire
